// File: list.f
source/icache_pkg.sv
source/line_memory.sv
source/icache_tag_array.sv
source/icache_data_sram.sv
source/icache_fetch_ctrl.sv
source/icache_top.sv
sim/icache_tb.sv

// File: sim/icache_tb.sv
module icache_tb import icache_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 10;
	localparam int RST_CYCLES = 4;
	// memory load plus a generous allowance for the directed tests
	localparam int BUDGET_CYCLES = RST_CYCLES + MEM_LINES + 972;
	// twice the budget, 40 us
	localparam int WATCHDOG_NS = 2 * BUDGET_CYCLES * CLK_PERIOD;

	logic clk = 1'b0;
	logic rst;

	// DUT inputs
	addr_t addr;
	logic valid;
	logic flush;
	logic load_en;
	addr_t load_addr;
	line_t load_line;

	// DUT outputs
	inst_t inst;
	logic ready;
	logic hit;

	// random stream state
	int seed;

	// reference copy of the backing memory
	line_t mem_copy [MEM_LINES];

	// reference cache state
	tag_t model_tag [WAYS][SETS];
	logic model_valid [WAYS][SETS];
	int model_victim;

	// response expected at the next falling edge
	logic pend_ready;
	logic pend_hit;
	inst_t pend_inst;

	icache_top dut (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_line(load_line),
		.inst(inst),
		.ready(ready),
		.hit(hit)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_with_failure();
		$display("Regression failed");
		$fatal(1, "stopping at the first error");
	endtask

	// compare one response field
	task automatic check_value(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERR %s %s expected %h actual %h", test, field, expected, actual);
			stop_with_failure();
		end
	endtask

	// fetch address from tag, set and word number
	function automatic addr_t line_addr(input tag_t t, input index_t s, input logic [1:0] w);
		return {t, s, w, 2'b00};
	endfunction

	// word a fetch of a returns, taken from the memory copy
	function automatic inst_t expected_word(input addr_t a);
		logic [MEM_IDX_W-1:0] li;
		logic [1:0] w;
		li = a[13:4];
		w = a[3:2];
		return mem_copy[li][w*INST_W +: INST_W];
	endfunction

	task automatic model_reset();
		for (int w = 0; w < WAYS; w++) begin
			for (int s = 0; s < SETS; s++) begin
				model_valid[w][s] = 1'b0;
				model_tag[w][s] = '0;
			end
		end
		model_victim = 0;
	endtask

	// lookup and fill, the pointer moves only on a fill
	task automatic model_access(input addr_t a, output logic found);
		index_t s;
		tag_t t;
		s = a[9:4];
		t = a[63:10];
		found = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			if (model_valid[w][s] && model_tag[w][s] == t) begin
				found = 1'b1;
			end
		end
		if (!found) begin
			model_tag[model_victim][s] = t;
			model_valid[model_victim][s] = 1'b1;
			model_victim = (model_victim + 1) % WAYS;
		end
	endtask

	// one clock of traffic
	// checks the response of the previous cycle, then drives the next inputs
	task automatic fetch_cycle(input string test, input logic v, input addr_t a,
			input logic fl);
		logic exp_hit;
		@(negedge clk);
		check_value(test, "ready", 32'(pend_ready), 32'(ready));
		check_value(test, "hit", 32'(pend_hit), 32'(hit));
		if (pend_ready) begin
			check_value(test, "inst", pend_inst, inst);
		end
		valid = v;
		addr = a;
		flush = fl;
		exp_hit = 1'b0;
		// a flushed request still updates the cache
		if (v) begin
			model_access(a, exp_hit);
		end
		pend_ready = v && !fl;
		pend_hit = v && !fl && exp_hit;
		pend_inst = expected_word(a);
	endtask

	task automatic idle_cycle(input string test);
		fetch_cycle(test, 1'b0, '0, 1'b0);
	endtask

	// every line gets random data, the copy mirrors it
	task automatic load_memory();
		line_t fresh;
		for (int i = 0; i < MEM_LINES; i++) begin
			@(negedge clk);
			fresh = {$random(seed), $random(seed), $random(seed), $random(seed)};
			load_en = 1'b1;
			load_addr = addr_t'(i) << OFFSET_W;
			load_line = fresh;
			mem_copy[i] = fresh;
		end
		@(negedge clk);
		load_en = 1'b0;
	endtask

	task automatic test_after_reset();
		repeat (4) begin
			idle_cycle("after_reset");
		end
	endtask

	task automatic test_cold_miss();
		addr_t a;
		a = line_addr(54'h1234, 6'd5, 2'd1);
		// cold miss, then the same word again
		fetch_cycle("cold_miss", 1'b1, a, 1'b0);
		fetch_cycle("cold_miss", 1'b1, a, 1'b0);
		// every word of the now resident line
		for (int w = 0; w < 4; w++) begin
			fetch_cycle("cold_miss", 1'b1, line_addr(54'h1234, 6'd5, w[1:0]), 1'b0);
		end
		idle_cycle("cold_miss");
	endtask

	task automatic test_conflict();
		addr_t lines [5];
		tag_t victim_tag;
		int evicted;
		// five tags on set 20
		for (int k = 0; k < 5; k++) begin
			lines[k] = line_addr(tag_t'(54'h2a0 + k * 3), 6'd20, k[1:0]);
		end
		// four fills in round-robin order
		for (int k = 0; k < 4; k++) begin
			fetch_cycle("conflict", 1'b1, lines[k], 1'b0);
		end
		// all four resident
		for (int k = 0; k < 4; k++) begin
			fetch_cycle("conflict", 1'b1, lines[k], 1'b0);
		end
		// line the fifth fill will push out
		victim_tag = model_tag[model_victim][20];
		evicted = -1;
		for (int k = 0; k < 4; k++) begin
			if (lines[k][63:10] == victim_tag) begin
				evicted = k;
			end
		end
		fetch_cycle("conflict", 1'b1, lines[4], 1'b0);
		// survivors and the new line still hit
		for (int k = 0; k < 5; k++) begin
			if (k != evicted) begin
				fetch_cycle("conflict", 1'b1, lines[k], 1'b0);
			end
		end
		// evicted line misses again
		fetch_cycle("conflict", 1'b1, lines[evicted], 1'b0);
		idle_cycle("conflict");
	endtask

	task automatic test_flush();
		addr_t a;
		addr_t b;
		addr_t c;
		a = line_addr(54'h3c00, 6'd33, 2'd0);
		b = line_addr(54'h3c01, 6'd34, 2'd2);
		c = line_addr(54'h3c02, 6'd35, 2'd3);
		// request sampled with flush, no response next cycle
		fetch_cycle("flush", 1'b1, a, 1'b1);
		fetch_cycle("flush", 1'b1, b, 1'b0);
		// b answers normally while c is dropped by the flush
		fetch_cycle("flush", 1'b1, c, 1'b1);
		// both flushed lines were still filled
		fetch_cycle("flush", 1'b1, a, 1'b0);
		fetch_cycle("flush", 1'b1, c, 1'b0);
		idle_cycle("flush");
	endtask

	// back-to-back traffic over a small pool of tags and two sets
	task automatic test_stream();
		int k;
		index_t s;
		logic [1:0] w;
		tag_t t;
		for (int n = 0; n < 200; n++) begin
			k = $unsigned($random(seed)) % 6;
			s = index_t'(40 + $unsigned($random(seed)) % 2);
			w = 2'($unsigned($random(seed)) % 4);
			// tags k and k+3 alias to the same memory line
			t = {k[2:0], 51'(k % 3)};
			fetch_cycle("stream", 1'b1, line_addr(t, s, w), 1'b0);
		end
		idle_cycle("stream");
	endtask

	// hard stop in case the DUT or a test loop stalls
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout, the tests did not complete in time");
		stop_with_failure();
	end

	initial begin
		seed = 20095;
		rst = 1'b1;
		addr = '0;
		valid = 1'b0;
		flush = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_line = '0;
		pend_ready = 1'b0;
		pend_hit = 1'b0;
		pend_inst = '0;
		model_reset();
		repeat (RST_CYCLES) begin
			@(negedge clk);
		end
		rst = 1'b0;
		test_after_reset();
		load_memory();
		test_cold_miss();
		test_conflict();
		test_flush();
		test_stream();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: source/icache_top.sv
module icache_top import icache_pkg::*; (
	input logic clk,
	input logic rst,

	// fetch request
	input addr_t addr,
	input logic valid,
	input logic flush,

	// memory load port
	input logic load_en,
	input addr_t load_addr,
	input line_t load_line,

	// response
	output inst_t inst,
	output logic ready,
	output logic hit
);

	// memory line at addr
	line_t line;

	// tag compare result
	way_mask_t way_hit;

	// SRAM controls from the controller
	way_mask_t way_en;
	logic way_we;
	way_mask_t fill_way;

	// per-way read data
	way_lines_t way_rdata;

	// set index for the SRAMs, bits 9:4
	index_t index;

	assign index = addr[OFFSET_W +: INDEX_W];

	// backing instruction memory
	line_memory u_line_memory (
		.clk(clk),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_line(load_line),
		.addr(addr),
		.line(line)
	);

	// tags and valid bits for all ways
	icache_tag_array u_tag_array (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.fill_way(fill_way),
		.way_hit(way_hit)
	);

	// one line SRAM per way
	// all share index, write level and fill data
	for (genvar w = 0; w < WAYS; w++) begin : g_way
		icache_data_sram u_data_sram (
			.clk(clk),
			.en(way_en[w]),
			.we(way_we),
			.index(index),
			.wdata(line),
			.rdata(way_rdata[w])
		);
	end

	// hit and fill decisions, victim, response path
	icache_fetch_ctrl u_fetch_ctrl (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.way_hit(way_hit),
		.line(line),
		.way_rdata(way_rdata),
		.way_en(way_en),
		.way_we(way_we),
		.fill_way(fill_way),
		.inst(inst),
		.ready(ready),
		.hit(hit)
	);

endmodule

// File: source/icache_fetch_ctrl.sv
module icache_fetch_ctrl import icache_pkg::*; (
	input logic clk,
	input logic rst,

	// fetch request
	input addr_t addr,
	input logic valid,
	input logic flush,

	// tag compare result for the current address
	input way_mask_t way_hit,

	// line from the backing memory at addr
	input line_t line,

	// registered outputs of the four data SRAMs
	input way_lines_t way_rdata,

	// SRAM controls
	output way_mask_t way_en,
	output logic way_we,

	// tag fill select
	output way_mask_t fill_way,

	// response, one cycle after the request
	output inst_t inst,
	output logic ready,
	output logic hit
);

	// any way matched
	logic any_hit;
	// valid request that missed, needs a fill
	logic fill;

	// round-robin victim, one-hot
	way_mask_t victim;

	// response state for the request taken at the last edge
	way_mask_t prev_way_hit;
	line_t bypass_line;
	logic [WORD_SEL_W-1:0] word_off;

	// line picked for the response
	line_t resp_line;

	assign any_hit = |way_hit;
	assign fill = valid && !any_hit;

	// hit reads the matching way, miss writes the victim way
	always_comb begin
		way_en = '0;
		if (valid) begin
			if (any_hit) begin
				way_en = way_hit;
			end else begin
				way_en = victim;
			end
		end
	end

	// single write level, only meaningful on the enabled way
	assign way_we = fill;

	// tags follow the same victim
	assign fill_way = fill ? victim : '0;

	// rotate one way per fill
	// flush does not stop this, the fill still lands
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_mask_t'(1);
		end else if (fill) begin
			victim <= {victim[WAYS-2:0], victim[WAYS-1]};
		end
	end

	// response control
	// flush drops the response due next cycle
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ready <= 1'b0;
			hit <= 1'b0;
			prev_way_hit <= '0;
		end else begin
			ready <= valid;
			hit <= valid && any_hit;
			// zero here selects the bypass line
			prev_way_hit <= valid ? way_hit : '0;
		end
	end

	// payload side, only loaded with a request
	always_ff @(posedge clk) begin
		if (valid) begin
			// missed line comes straight from memory
			bypass_line <= line;
			// bits 3:2 pick the word
			word_off <= addr[OFFSET_W-1 -: WORD_SEL_W];
		end
	end

	// hitting way's SRAM output, else the bypass register
	always_comb begin
		resp_line = bypass_line;
		for (int w = 0; w < WAYS; w++) begin
			if (prev_way_hit[w]) begin
				resp_line = way_rdata[w];
			end
		end
	end

	// word extraction, word 0 in the low bits
	assign inst = resp_line[word_off*INST_W +: INST_W];

endmodule

// File: source/icache_data_sram.sv
module icache_data_sram import icache_pkg::*; (
	input logic clk,

	// chip enable and write enable, both active high
	input logic en,
	input logic we,

	// set index shared by read and write
	input index_t index,

	// fill line from the backing memory
	input line_t wdata,

	// registered read data
	output line_t rdata
);

	// one way's worth of lines
	line_t mem [SETS];

	// single port, either read or write per enabled cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				// write does not update rdata
				mem[index] <= wdata;
			end else begin
				rdata <= mem[index];
			end
		end
	end

	// rdata holds its last value while en is low
	// the controller only looks at it the cycle after a hit read

endmodule

// File: source/icache_tag_array.sv
module icache_tag_array import icache_pkg::*; (
	input logic clk,
	input logic rst,

	// fetch address of the current request
	input addr_t addr,

	// way being filled this cycle, zero when nothing fills
	input way_mask_t fill_way,

	// per-way compare result, combinational
	output way_mask_t way_hit
);

	// tag store per way and set
	tag_t tags [WAYS][SETS];

	// one valid bit per set for each way
	logic [SETS-1:0] valid_bits [WAYS];

	// set index and tag pulled out of the address
	index_t idx;
	tag_t addr_tag;

	assign idx = addr[OFFSET_W +: INDEX_W];
	assign addr_tag = addr[ADDR_W-1 -: TAG_W];

	// compare all ways in parallel
	// a stale tag never hits once its valid bit is low
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = valid_bits[w][idx] && (tags[w][idx] == addr_tag);
		end
	end

	// valid bits are control state, cleared by reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				// set on fill, never cleared otherwise
				if (fill_way[w]) begin
					valid_bits[w][idx] <= 1'b1;
				end
			end
		end
	end

	// tag write on fill
	// fill_way is one-hot so at most one way changes
	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (fill_way[w]) begin
				tags[w][idx] <= addr_tag;
			end
		end
	end

	// the new tag shows up in way_hit right after the edge
	// so a repeat of the filled line one cycle later hits

endmodule

// File: source/line_memory.sv
module line_memory import icache_pkg::*; (
	input logic clk,

	// line-wide load side, used before fetching starts
	input logic load_en,
	input addr_t load_addr,
	input line_t load_line,

	// fetch side, combinational read
	input addr_t addr,
	output line_t line
);

	// line storage, no reset on the array
	line_t mem [MEM_LINES];

	// line index for both sides
	logic [MEM_IDX_W-1:0] load_idx;
	logic [MEM_IDX_W-1:0] read_idx;

	// only bits 13:4 pick a line
	// upper bits are dropped so the image repeats every 16 KiB
	assign load_idx = load_addr[OFFSET_W +: MEM_IDX_W];
	assign read_idx = addr[OFFSET_W +: MEM_IDX_W];

	// whole line written at the edge
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_idx] <= load_line;
		end
	end

	// read is asynchronous so a miss can fill in the same cycle
	// note the read follows addr even when no fetch is valid
	assign line = mem[read_idx];

endmodule

// File: source/icache_pkg.sv
package icache_pkg;

	// fetch address width
	localparam int ADDR_W = 64;

	// cache geometry, 4 ways by 64 sets of 16-byte lines
	localparam int WAYS = 4;
	localparam int SETS = 64;

	// index sits at address bits 9:4
	localparam int INDEX_W = 6;
	// byte offset inside a line, bits 3:0
	localparam int OFFSET_W = 4;
	// tag is everything above the index, bits 63:10
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	// line and instruction word sizes
	localparam int LINE_W = 128;
	localparam int INST_W = 32;
	// word select inside a line, address bits 3:2
	localparam int WORD_SEL_W = 2;

	// backing memory is 16 KiB of lines, indexed by bits 13:4
	localparam int MEM_LINES = 1024;
	localparam int MEM_IDX_W = 10;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;

	// word 0 lives in the low 32 bits
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [INST_W-1:0] inst_t;

	// one bit per way, one-hot or all zero
	typedef logic [WAYS-1:0] way_mask_t;

	// one line per way, slot w belongs to way w
	typedef line_t [WAYS-1:0] way_lines_t;

endpackage
